//--- trap_pkg.sv
/*
  trap controller package
  widths, cause codes and the record and event types shared by the trap blocks
*/
package trap_pkg;

  // data and address width
  localparam int unsigned xlen = 32;
  // number of fast interrupt lines
  localparam int unsigned num_fast_irq = 15;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // interrupt lines sampled along with each instruction
  typedef struct packed {
    logic                    nm;
    logic [num_fast_irq-1:0] fast;
    logic                    external;
    logic                    software;
    logic                    timer;
    logic                    mie;
  } irq_sample_t;

  // instruction record as seen at the controller input
  typedef struct packed {
    logic              illegal;
    logic              ecall;
    logic              ebreak;
    logic              mret;
    logic              fetch_err;
    logic              fetch_err_plus2;
    logic              is_compressed;
    logic [31:0]       instr;
    logic [15:0]       instr_c;
    logic [xlen-1:0]   pc;
    priv_lvl_e         priv;
    irq_sample_t       irq;
  } instr_rec_t;

  // classifier verdict, one per record
  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_FETCH_FAULT,
    KIND_ILLEGAL,
    KIND_ECALL,
    KIND_EBREAK,
    KIND_MRET
  } exc_kind_e;

  // classified record held in the FIFO
  typedef struct packed {
    exc_kind_e       kind;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] pc;
    priv_lvl_e       priv;
    irq_sample_t     irq;
  } trap_rec_t;

  // mcause codes, bit 5 flags an interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_NONE               = 6'd0,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'd35,
    EXC_CAUSE_IRQ_TIMER_M        = 6'd39,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'd43,
    EXC_CAUSE_IRQ_FAST_0         = 6'd48,
    EXC_CAUSE_IRQ_FAST_1         = 6'd49,
    EXC_CAUSE_IRQ_FAST_2         = 6'd50,
    EXC_CAUSE_IRQ_FAST_3         = 6'd51,
    EXC_CAUSE_IRQ_FAST_4         = 6'd52,
    EXC_CAUSE_IRQ_FAST_5         = 6'd53,
    EXC_CAUSE_IRQ_FAST_6         = 6'd54,
    EXC_CAUSE_IRQ_FAST_7         = 6'd55,
    EXC_CAUSE_IRQ_FAST_8         = 6'd56,
    EXC_CAUSE_IRQ_FAST_9         = 6'd57,
    EXC_CAUSE_IRQ_FAST_10        = 6'd58,
    EXC_CAUSE_IRQ_FAST_11        = 6'd59,
    EXC_CAUSE_IRQ_FAST_12        = 6'd60,
    EXC_CAUSE_IRQ_FAST_13        = 6'd61,
    EXC_CAUSE_IRQ_FAST_14        = 6'd62,
    EXC_CAUSE_IRQ_NM             = 6'd63
  } exc_cause_e;

  // redirect target for the fetch stage
  typedef enum logic [1:0] {
    PC_NEXT,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // trap event towards the CSRs and fetch
  typedef struct packed {
    pc_sel_e         pc_sel;
    exc_cause_e      cause;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] epc;
    logic            save_cause;
  } trap_evt_t;

endpackage

//--- trap_classifier.sv
/*
  trap classifier
  qualifies instruction records, picks the synchronous exception by priority
  and holds the credit count for the record FIFO
*/
`timescale 1ns/1ps
module trap_classifier #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid_i,
  input  trap_pkg::instr_rec_t in_rec_i,
  output logic                 in_ready_o,
  input  logic                 credit_return_i,
  output logic                 push_valid_o,
  output trap_pkg::trap_rec_t  push_rec_o
);

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CNT_W-1:0]          credit_q;
  logic [CNT_W-1:0]          credit_d;
  logic                      accept;
  logic                      illegal_umode;
  trap_pkg::exc_kind_e       kind;
  logic [trap_pkg::xlen-1:0] mtval;
  logic                      push_valid_q;
  trap_pkg::trap_rec_t       push_rec_q;

  ////////////////////////////////
  // exception priority
  ////////////////////////////////

  // mret is only legal from machine mode
  assign illegal_umode = in_rec_i.mret & (in_rec_i.priv != trap_pkg::PRIV_LVL_M);

  always_comb begin
    kind  = trap_pkg::KIND_NONE;
    mtval = '0;
    if (in_rec_i.fetch_err) begin
      kind  = trap_pkg::KIND_FETCH_FAULT;
      // faulting half sits in the upper parcel
      mtval = in_rec_i.fetch_err_plus2 ? (in_rec_i.pc + trap_pkg::xlen'(2)) : in_rec_i.pc;
    end else if (in_rec_i.illegal | illegal_umode) begin
      kind  = trap_pkg::KIND_ILLEGAL;
      mtval = in_rec_i.is_compressed ? {16'b0, in_rec_i.instr_c} : in_rec_i.instr;
    end else if (in_rec_i.ecall) begin
      kind = trap_pkg::KIND_ECALL;
    end else if (in_rec_i.ebreak) begin
      kind = trap_pkg::KIND_EBREAK;
    end else if (in_rec_i.mret) begin
      kind = trap_pkg::KIND_MRET;
    end
  end

  ////////////////////////////////
  // credits and output register
  ////////////////////////////////

  // a push in flight already owns a slot
  assign in_ready_o = credit_q > CNT_W'(push_valid_q);
  assign accept     = in_valid_i & in_ready_o;

  // spend on push, refund on pop
  always_comb begin
    credit_d = credit_q;
    if (push_valid_q && !credit_return_i) begin
      credit_d = credit_q - CNT_W'(1);
    end else if (!push_valid_q && credit_return_i) begin
      credit_d = credit_q + CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q     <= CNT_W'(FIFO_DEPTH);
      push_valid_q <= 1'b0;
    end else begin
      credit_q     <= credit_d;
      push_valid_q <= accept;
    end
  end

  // payload only loads on an accepted record
  always_ff @(posedge clk_i) begin
    if (accept) begin
      push_rec_q.kind  <= kind;
      push_rec_q.mtval <= mtval;
      push_rec_q.pc    <= in_rec_i.pc;
      push_rec_q.priv  <= in_rec_i.priv;
      push_rec_q.irq   <= in_rec_i.irq;
    end
  end

  assign push_valid_o = push_valid_q;
  assign push_rec_o   = push_rec_q;

endmodule

//--- trap_fifo.sv
/*
  record FIFO
  first-word-fall-through circular buffer, one credit pulse per pop
*/
`timescale 1ns/1ps
module trap_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     valid_o,
  output payload_t data_o,
  output logic     credit_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  // pop only counts while a head is present
  assign do_pop = pop_i & valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // occupancy moves only on a lone push or pop
      if (push_i && !do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (!push_i && do_pop) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // storage, overflow is prevented upstream by the credits
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign valid_o  = count_q != '0;
  assign data_o   = mem_q[rd_ptr_q];
  assign credit_o = do_pop;

endmodule

//--- trap_sequencer.sv
/*
  trap sequencer
  arbitrates interrupts against the record's exception, tracks NMI mode
  and issues one registered trap event per record
*/
`timescale 1ns/1ps
module trap_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                head_valid_i,
  input  trap_pkg::trap_rec_t head_i,
  output logic                pop_o,
  output logic                evt_valid_o,
  output trap_pkg::trap_evt_t evt_o,
  input  logic                evt_ready_i,
  output logic                nmi_mode_o
);

  logic                 nmi_mode_q;
  logic                 nmi_mode_d;
  logic                 take_nmi;
  logic                 take_irq;
  logic                 irq_pending;
  logic [3:0]           fast_id;
  logic                 evt_valid_q;
  trap_pkg::trap_evt_t  evt_q;
  trap_pkg::trap_evt_t  evt_d;
  trap_pkg::irq_sample_t irq;

  assign irq = head_i.irq;

  ////////////////////////////////
  // interrupt arbitration
  ////////////////////////////////

  // nested NMIs are not taken
  assign take_nmi    = irq.nm & ~nmi_mode_q;
  assign irq_pending = (|irq.fast) | irq.external | irq.software | irq.timer;
  // maskable lines stay blocked inside the NMI handler
  assign take_irq    = ~nmi_mode_q & irq.mie & irq_pending;

  // highest fast index wins
  always_comb begin
    fast_id = 4'd0;
    for (int i = 0; i < trap_pkg::num_fast_irq; i++) begin
      if (irq.fast[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  ////////////////////////////////
  // event selection
  ////////////////////////////////

  always_comb begin
    nmi_mode_d       = nmi_mode_q;
    evt_d.pc_sel     = trap_pkg::PC_NEXT;
    evt_d.cause      = trap_pkg::EXC_CAUSE_NONE;
    evt_d.mtval      = head_i.mtval;
    evt_d.epc        = head_i.pc;
    evt_d.save_cause = 1'b0;
    if (take_nmi || take_irq) begin
      evt_d.pc_sel     = trap_pkg::PC_EXC;
      evt_d.mtval      = '0;
      evt_d.save_cause = 1'b1;
      if (take_nmi) begin
        evt_d.cause = trap_pkg::EXC_CAUSE_IRQ_NM;
        nmi_mode_d  = 1'b1;
      end else if (|irq.fast) begin
        // upper bits 11 place fast ids at 48 and up
        evt_d.cause = trap_pkg::exc_cause_e'({2'b11, fast_id});
      end else if (irq.external) begin
        evt_d.cause = trap_pkg::EXC_CAUSE_IRQ_EXTERNAL_M;
      end else if (irq.software) begin
        evt_d.cause = trap_pkg::EXC_CAUSE_IRQ_SOFTWARE_M;
      end else begin
        evt_d.cause = trap_pkg::EXC_CAUSE_IRQ_TIMER_M;
      end
    end else begin
      unique case (head_i.kind)
        trap_pkg::KIND_FETCH_FAULT: evt_d.cause = trap_pkg::EXC_CAUSE_INSTR_ACCESS_FAULT;
        trap_pkg::KIND_ILLEGAL:     evt_d.cause = trap_pkg::EXC_CAUSE_ILLEGAL_INSN;
        trap_pkg::KIND_EBREAK:      evt_d.cause = trap_pkg::EXC_CAUSE_BREAKPOINT;
        trap_pkg::KIND_ECALL: begin
          evt_d.cause = (head_i.priv == trap_pkg::PRIV_LVL_M) ?
                        trap_pkg::EXC_CAUSE_ECALL_MMODE : trap_pkg::EXC_CAUSE_ECALL_UMODE;
        end
        // return from handler, leaves NMI mode
        trap_pkg::KIND_MRET: begin
          evt_d.pc_sel = trap_pkg::PC_ERET;
          nmi_mode_d   = 1'b0;
        end
        default: ;
      endcase
      if (head_i.kind inside {trap_pkg::KIND_FETCH_FAULT, trap_pkg::KIND_ILLEGAL,
                              trap_pkg::KIND_ECALL, trap_pkg::KIND_EBREAK}) begin
        evt_d.pc_sel     = trap_pkg::PC_EXC;
        evt_d.save_cause = 1'b1;
      end
    end
  end

  ////////////////////////////////
  // output register and state
  ////////////////////////////////

  // take the head when the slot is free or draining
  assign pop_o = head_valid_i & (~evt_valid_q | evt_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_valid_q <= 1'b0;
      nmi_mode_q  <= 1'b0;
    end else begin
      if (pop_o) begin
        evt_valid_q <= 1'b1;
        nmi_mode_q  <= nmi_mode_d;
      end else if (evt_ready_i) begin
        evt_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      evt_q <= evt_d;
    end
  end

  assign evt_valid_o = evt_valid_q;
  assign evt_o       = evt_q;
  assign nmi_mode_o  = nmi_mode_q;

endmodule

//--- trap_ctrl_top.sv
/*
  trap controller top
  classifier, record FIFO and sequencer joined by a credit link
*/
`timescale 1ns/1ps
module trap_ctrl_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid_i,
  input  trap_pkg::instr_rec_t in_rec_i,
  output logic                 in_ready_o,
  output logic                 evt_valid_o,
  output trap_pkg::trap_evt_t  evt_o,
  input  logic                 evt_ready_i,
  output logic                 nmi_mode_o
);

  // classifier to FIFO
  logic                push_valid;
  trap_pkg::trap_rec_t push_rec;
  logic                credit_return;
  // FIFO to sequencer
  logic                head_valid;
  trap_pkg::trap_rec_t head;
  logic                pop;

  trap_classifier #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_classifier (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_valid_i      (in_valid_i),
    .in_rec_i        (in_rec_i),
    .in_ready_o      (in_ready_o),
    .credit_return_i (credit_return),
    .push_valid_o    (push_valid),
    .push_rec_o      (push_rec)
  );

  trap_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (trap_pkg::trap_rec_t)
  ) u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push_valid),
    .data_i   (push_rec),
    .pop_i    (pop),
    .valid_o  (head_valid),
    .data_o   (head),
    .credit_o (credit_return)
  );

  trap_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_valid_i (head_valid),
    .head_i       (head),
    .pop_o        (pop),
    .evt_valid_o  (evt_valid_o),
    .evt_o        (evt_o),
    .evt_ready_i  (evt_ready_i),
    .nmi_mode_o   (nmi_mode_o)
  );

endmodule

//--- trap_ctrl_sva.sv
/*
  trap controller assertions
  credit and output handshake rules, bound into the top level
*/
`timescale 1ns/1ps
module trap_ctrl_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                in_ready_i,
  input logic                push_valid_i,
  input logic                credit_zero_i,
  input logic                no_room_i,
  input logic                evt_valid_i,
  input logic                evt_ready_i,
  input trap_pkg::trap_evt_t evt_i
);

  // a push always owns a slot
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_valid_i && credit_zero_i))
    else $error("push issued with no credit left");

  // stalled event must hold still
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_valid_i && !evt_ready_i |=> evt_valid_i && $stable(evt_i))
    else $error("event changed while stalled");

  // input stalls once stored and in-flight records fill every slot
  assert property (@(posedge clk_i) disable iff (!rst_ni) no_room_i |-> !in_ready_i)
    else $error("input ready with no free FIFO slot");

endmodule

bind trap_ctrl_top trap_ctrl_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .in_ready_i    (in_ready_o),
  .push_valid_i  (push_valid),
  .credit_zero_i (u_classifier.credit_q == '0),
  .no_room_i     ((32'(u_fifo.count_q) + 32'(push_valid)) >= FIFO_DEPTH),
  .evt_valid_i   (evt_valid_o),
  .evt_ready_i   (evt_ready_i),
  .evt_i         (evt_o)
);

//--- tb_trap_model.svh
/*
  trap controller reference model
  expected trap event and next NMI mode for one input record
*/
`ifndef TB_TRAP_MODEL_SVH
`define TB_TRAP_MODEL_SVH

function automatic trap_pkg::trap_evt_t model_event(
  input  trap_pkg::instr_rec_t rec,
  input  logic                 nmi_in,
  output logic                 nmi_out
);
  trap_pkg::trap_evt_t evt;
  logic                in_m;
  logic                irq_any;
  int                  code;
  in_m           = rec.priv == trap_pkg::PRIV_LVL_M;
  irq_any        = (|rec.irq.fast) | rec.irq.external | rec.irq.software | rec.irq.timer;
  // -1 means no cause gets saved
  code           = -1;
  nmi_out        = nmi_in;
  evt.pc_sel     = trap_pkg::PC_NEXT;
  evt.mtval      = '0;
  evt.epc        = rec.pc;
  // NMI ahead of everything, maskable lines blocked while in NMI mode
  if (rec.irq.nm && !nmi_in) begin
    code    = 63;
    nmi_out = 1'b1;
  end else if (!nmi_in && rec.irq.mie && irq_any) begin
    if (|rec.irq.fast) begin
      // last hit is the highest index
      for (int i = 0; i < 15; i++) begin
        if (rec.irq.fast[i]) begin
          code = 48 + i;
        end
      end
    end else if (rec.irq.external) begin
      code = 43;
    end else if (rec.irq.software) begin
      code = 35;
    end else begin
      code = 39;
    end
  end else if (rec.fetch_err) begin
    code      = 1;
    evt.mtval = rec.fetch_err_plus2 ? rec.pc + 32'd2 : rec.pc;
  end else if (rec.illegal || (rec.mret && !in_m)) begin
    // mret below M mode counts as illegal
    code      = 2;
    evt.mtval = rec.is_compressed ? {16'h0, rec.instr_c} : rec.instr;
  end else if (rec.ecall) begin
    code = in_m ? 11 : 8;
  end else if (rec.ebreak) begin
    code = 3;
  end else if (rec.mret) begin
    evt.pc_sel = trap_pkg::PC_ERET;
    nmi_out    = 1'b0;
  end
  evt.save_cause = code >= 0;
  evt.cause      = trap_pkg::exc_cause_e'((code >= 0) ? code[5:0] : 6'd0);
  if (code >= 0) begin
    evt.pc_sel = trap_pkg::PC_EXC;
  end
  return evt;
endfunction

`endif

//--- tb_trap_ctrl.sv
/*
  trap controller testbench
  directed and random records, scoreboard against the reference model,
  random back-pressure on the event output
*/
`timescale 1ns/1ps
module tb_trap_ctrl;

  localparam int N_DIRECTED  = 24;
  localparam int N_RANDOM    = 400;
  localparam int CYCLE_LIMIT = 40 * (N_DIRECTED + N_RANDOM) + 200;

  // decoder flag masks, same order as the record fields
  localparam logic [6:0] flg_ill   = 7'b1000000;
  localparam logic [6:0] flg_ecall = 7'b0100000;
  localparam logic [6:0] flg_ebrk  = 7'b0010000;
  localparam logic [6:0] flg_mret  = 7'b0001000;
  localparam logic [6:0] flg_fetch = 7'b0000100;
  localparam logic [6:0] flg_plus2 = 7'b0000010;
  localparam logic [6:0] flg_comp  = 7'b0000001;
  localparam trap_pkg::priv_lvl_e m_mode = trap_pkg::PRIV_LVL_M;
  localparam trap_pkg::priv_lvl_e u_mode = trap_pkg::PRIV_LVL_U;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 in_valid_i;
  trap_pkg::instr_rec_t in_rec_i;
  logic                 in_ready_o;
  logic                 evt_valid_o;
  trap_pkg::trap_evt_t  evt_o;
  logic                 evt_ready_i;
  logic                 nmi_mode_o;

  int                   seed = 71101;
  int                   err_count = 0;
  int                   cycle_count = 0;
  logic                 bp_en = 1'b0;
  logic                 saw_ready_low = 1'b0;
  logic                 model_nmi = 1'b0;
  trap_pkg::instr_rec_t exp_q [$];
  trap_pkg::instr_rec_t rand_recs [N_RANDOM];

  `include "tb_trap_model.svh"

  trap_ctrl_top #(
    .FIFO_DEPTH (4)
  ) DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_rec_i    (in_rec_i),
    .in_ready_o  (in_ready_o),
    .evt_valid_o (evt_valid_o),
    .evt_o       (evt_o),
    .evt_ready_i (evt_ready_i),
    .nmi_mode_o  (nmi_mode_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // lines is {nm, external, software, timer, mie}
  function automatic trap_pkg::irq_sample_t irq_lines(input logic [14:0] fast,
                                                      input logic [4:0]  lines);
    trap_pkg::irq_sample_t irq;
    {irq.nm, irq.external, irq.software, irq.timer, irq.mie} = lines;
    irq.fast = fast;
    return irq;
  endfunction

  function automatic trap_pkg::instr_rec_t directed_record(
    input logic [31:0]           pc,
    input logic [6:0]            flags,
    input trap_pkg::priv_lvl_e   priv,
    input trap_pkg::irq_sample_t irq
  );
    trap_pkg::instr_rec_t rec;
    rec = '0;
    {rec.illegal, rec.ecall, rec.ebreak, rec.mret, rec.fetch_err, rec.fetch_err_plus2,
     rec.is_compressed} = flags;
    // instruction words derived from pc so each record is distinct
    rec.instr   = {pc[15:0], 16'h1073};
    rec.instr_c = pc[15:0] ^ 16'h9c02;
    rec.pc      = pc;
    rec.priv    = priv;
    rec.irq     = irq;
    return rec;
  endfunction

  task automatic make_random_record(output trap_pkg::instr_rec_t rec);
    logic [31:0] f;
    logic [31:0] g;
    logic [31:0] h;
    f = $random(seed);
    g = $random(seed);
    h = $random(seed);
    rec = '0;
    // flags roughly one in eight, mret one in four to leave NMI mode often
    rec.illegal          = f[2:0] == 3'd0;
    rec.ecall            = f[5:3] == 3'd0;
    rec.ebreak           = f[8:6] == 3'd0;
    rec.mret             = f[10:9] == 2'd0;
    rec.fetch_err        = f[14:12] == 3'd0;
    rec.fetch_err_plus2  = f[15];
    rec.is_compressed    = f[16];
    rec.priv             = (f[18:17] != 2'b00) ? m_mode : u_mode;
    rec.irq.nm           = f[22:19] == 4'd0;
    rec.irq.fast         = (f[25:23] == 3'd0) ? h[14:0] : 15'h0;
    rec.irq.external     = f[28:26] == 3'd0;
    rec.irq.software     = f[31:29] == 3'd0;
    rec.irq.timer        = g[18:16] == 3'd0;
    rec.irq.mie          = g[19];
    rec.instr_c          = g[15:0];
    rec.instr            = $random(seed);
    rec.pc               = $random(seed);
    rec.pc[0]            = 1'b0;
  endtask

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_record(input trap_pkg::instr_rec_t rec);
    logic accepted;
    in_valid_i = 1'b1;
    in_rec_i   = rec;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = in_ready_o;
      @(posedge clk_i);
    end
    exp_q.push_back(rec);
    #1;
    in_valid_i = 1'b0;
  endtask

  //////////////////////////////
  // clock, watchdog, back-pressure
  //////////////////////////////

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  initial begin : watchdog
    while (cycle_count <= CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d records never came out", cycle_count, exp_q.size());
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin : back_pressure
    logic [31:0] r;
    int          hold;
    evt_ready_i = 1'b1;
    hold        = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!bp_en) begin
        evt_ready_i = 1'b1;
      end else if (hold == 0) begin
        r           = $random(seed);
        hold        = int'(r[3:0]);
        evt_ready_i = ~evt_ready_i;
      end else begin
        hold--;
      end
    end
  end

  //////////////////////////////
  // scoreboard
  //////////////////////////////

  // sampled mid-cycle, the handshake completes at the next rising edge
  always @(negedge clk_i) begin : compare_events
    trap_pkg::instr_rec_t rec;
    trap_pkg::trap_evt_t  exp_evt;
    logic                 next_nmi;
    if (rst_ni) begin
      if (!in_ready_o) begin
        saw_ready_low = 1'b1;
      end
      if (evt_valid_o && evt_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("event at %0t has no record waiting for it", $time);
          $display("ERRORS FOUND");
          $fatal(1);
        end else begin
          rec     = exp_q.pop_front();
          exp_evt = model_event(rec, model_nmi, next_nmi);
          check_value("evt_o.pc_sel", 64'(evt_o.pc_sel), 64'(exp_evt.pc_sel));
          check_value("evt_o.cause", 64'(evt_o.cause), 64'(exp_evt.cause));
          check_value("evt_o.mtval", 64'(evt_o.mtval), 64'(exp_evt.mtval));
          check_value("evt_o.epc", 64'(evt_o.epc), 64'(exp_evt.epc));
          check_value("evt_o.save_cause", 64'(evt_o.save_cause), 64'(exp_evt.save_cause));
          check_value("nmi_mode_o", 64'(nmi_mode_o), 64'(next_nmi));
          model_nmi = next_nmi;
        end
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    rst_ni     = 1'b0;
    in_valid_i = 1'b0;
    in_rec_i   = '0;
    for (int i = 0; i < N_RANDOM; i++) begin
      make_random_record(rand_recs[i]);
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("evt_valid_o after reset", 64'(evt_valid_o), 64'd0);
    check_value("nmi_mode_o after reset", 64'(nmi_mode_o), 64'd0);
    check_value("in_ready_o after reset", 64'(in_ready_o), 64'd1);
    @(posedge clk_i);
    #1;

    // exception priority and mtval
    send_record(directed_record(32'h100, flg_fetch | flg_ill | flg_ecall, m_mode, '0));
    send_record(directed_record(32'h104, flg_fetch | flg_plus2 | flg_ebrk, m_mode, '0));
    send_record(directed_record(32'h108, flg_ill | flg_ecall | flg_ebrk | flg_comp, m_mode, '0));
    send_record(directed_record(32'h10c, flg_ill, m_mode, '0));
    send_record(directed_record(32'h110, flg_ecall | flg_ebrk, m_mode, '0));
    send_record(directed_record(32'h114, flg_ebrk, u_mode, '0));
    // privilege rules
    send_record(directed_record(32'h118, flg_ecall, u_mode, '0));
    send_record(directed_record(32'h11c, flg_mret, u_mode, '0));
    send_record(directed_record(32'h120, flg_mret, m_mode, '0));
    send_record(directed_record(32'h124, 7'b0, m_mode, '0));
    // interrupt arbitration, fast lines by highest index
    send_record(directed_record(32'h200, flg_ill, m_mode, irq_lines(15'h0208, 5'b00001)));
    send_record(directed_record(32'h204, 7'b0, u_mode, irq_lines(15'h4001, 5'b01001)));
    send_record(directed_record(32'h208, flg_ecall, m_mode, irq_lines(15'h0, 5'b01111)));
    send_record(directed_record(32'h20c, 7'b0, m_mode, irq_lines(15'h0, 5'b00111)));
    send_record(directed_record(32'h210, flg_fetch, m_mode, irq_lines(15'h0, 5'b00011)));
    // masked by mie
    send_record(directed_record(32'h214, flg_ecall, u_mode, irq_lines(15'h7fff, 5'b01110)));
    // NMI entry, then nested and maskable lines ignored
    send_record(directed_record(32'h300, 7'b0, m_mode, irq_lines(15'h0010, 5'b10001)));
    send_record(directed_record(32'h304, flg_ebrk, m_mode, irq_lines(15'h0010, 5'b00001)));
    send_record(directed_record(32'h308, flg_ill, m_mode, irq_lines(15'h0, 5'b10001)));
    send_record(directed_record(32'h30c, flg_mret, u_mode, '0));
    send_record(directed_record(32'h310, flg_mret, m_mode, irq_lines(15'h0, 5'b00000)));
    send_record(directed_record(32'h314, 7'b0, m_mode, irq_lines(15'h0, 5'b00011)));
    send_record(directed_record(32'h318, 7'b0, u_mode, irq_lines(15'h0, 5'b10000)));
    send_record(directed_record(32'h31c, flg_mret, m_mode, '0));

    // random records, second half under back-pressure
    for (int i = 0; i < N_RANDOM; i++) begin
      if (i == N_RANDOM / 2) begin
        bp_en = 1'b1;
      end
      send_record(rand_recs[i]);
    end
    bp_en = 1'b0;
    wait (exp_q.size() == 0);
    // room for a stray extra event to show up
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    check_value("in_ready_o low under back-pressure", 64'(saw_ready_low), 64'd1);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
trap_pkg.sv
trap_classifier.sv
trap_fifo.sv
trap_sequencer.sv
trap_ctrl_top.sv
trap_ctrl_sva.sv
tb_trap_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the trap controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project directory"
  exit 1
fi

verilator --binary --timing --assert -f flist.f --top-module tb_trap_ctrl -o sim_trap_ctrl
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_trap_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"
exit 0
